// File: logic/mdu_op_pkg.sv
/* Operation encoding and widths shared by the multiply/divide unit
   Only 32-bit operands are supported */

package mdu_op_pkg;

  // Operand and result width
  localparam int XLEN = 32;

  // Operation class issued to the unit
  typedef enum logic [1:0] {
    MDU_MUL  = 2'b00,  // Low product word
    MDU_MULH = 2'b01,  // High product word, signedness from short_signed
    MDU_DIV  = 2'b10,  // Quotient
    MDU_REM  = 2'b11   // Remainder
  } mdu_op_e;

  // Bit positions in short_signed
  localparam int SIGN_A_BIT = 0;
  localparam int SIGN_B_BIT = 1;

  // Both operands signed, used by MULH and signed DIV/REM
  // MULHSU uses 2'b01 and the unsigned forms use 2'b00
  localparam logic [1:0] SIGNED_SIGNED = 2'b11;

  // Divider iteration count and step counter
  localparam int DIV_STEPS = 32;
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);
  localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS - 1);

endpackage

// File: logic/mdu_state_pkg.sv
/* Sequencer state encodings of the multiplier and the divider */

package mdu_state_pkg;

  // Partial product in progress for the high-half multiply
  // ALBL doubles as the idle state
  typedef enum logic [1:0] {
    ALBL = 2'b00,
    ALBH = 2'b01,
    AHBL = 2'b10,
    AHBH = 2'b11
  } mult_state_e;

  // Serial divider sequencer
  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,  // Waiting for issue, loads magnitudes
    DIV_RUN  = 2'b01,  // One shift/subtract step per cycle
    DIV_DONE = 2'b10   // Result held until ex_ready
  } div_state_e;

endpackage

// File: logic/mdu_req_if.sv
/* Issued operation and stall input as seen by the units
   The issuer keeps every field stable until the unit reports ready */

`timescale 1ns/1ps

interface mdu_req_if;

  logic                          enable;
  mdu_op_pkg::mdu_op_e           operator;
  logic [1:0]                    short_signed;
  logic [mdu_op_pkg::XLEN-1:0]   op_a;
  logic [mdu_op_pkg::XLEN-1:0]   op_b;
  logic                          ex_ready;

  // Multiplier and divider see the whole request
  modport unit (
    input enable, operator, short_signed, op_a, op_b, ex_ready
  );

  // Result merging only needs the operation and operands
  modport merge (
    input operator, short_signed, op_a, op_b
  );

endinterface

// File: logic/mdu_mult.sv
/* MUL is combinational; MULH, MULHSU and MULHU take four cycles
   Operands must stay stable while the high-half sequence runs */

`timescale 1ns/1ps

module mdu_mult (
  input  logic                         clk,
  input  logic                         rst_n,
  mdu_req_if.unit                      req,
  output logic [mdu_op_pkg::XLEN-1:0]  result_o,
  output logic                         ready_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  // Shared multiplier operands, one bit wider than the data
  logic [mdu_op_pkg::XLEN:0]      op_a;
  logic [mdu_op_pkg::XLEN:0]      op_b;
  logic [2*mdu_op_pkg::XLEN+1:0]  int_prod;
  logic [mdu_op_pkg::XLEN+1:0]    int_result;

  // High-half sequencer
  logic                           mulh_active;
  logic                           mulh_busy;
  logic                           mulh_shift;
  mdu_state_pkg::mult_state_e     mulh_state;
  mdu_state_pkg::mult_state_e     mulh_state_next;

  // 17-bit halfword operands
  logic [16:0]                    mulh_al;
  logic [16:0]                    mulh_bl;
  logic [16:0]                    mulh_ah;
  logic [16:0]                    mulh_bh;
  logic [16:0]                    mulh_a;
  logic [16:0]                    mulh_b;

  // Accumulation path
  logic [mdu_op_pkg::XLEN:0]      mulh_acc;
  logic [mdu_op_pkg::XLEN+1:0]    mulh_sum;
  logic [mdu_op_pkg::XLEN+1:0]    mulh_sum_shifted;
  logic [mdu_op_pkg::XLEN+1:0]    mulh_result;

  assign mulh_active = req.enable && (req.operator == mdu_op_pkg::MDU_MULH);

  // Lower halfwords are always unsigned
  assign mulh_al = {1'b0, req.op_a[15:0]};
  assign mulh_bl = {1'b0, req.op_b[15:0]};

  // Upper halfwords carry the operand sign when short_signed asks for it
  assign mulh_ah = {req.short_signed[mdu_op_pkg::SIGN_A_BIT] & req.op_a[mdu_op_pkg::XLEN-1],
                    req.op_a[mdu_op_pkg::XLEN-1:16]};
  assign mulh_bh = {req.short_signed[mdu_op_pkg::SIGN_B_BIT] & req.op_b[mdu_op_pkg::XLEN-1],
                    req.op_b[mdu_op_pkg::XLEN-1:16]};

  // Add the partial product, optionally dropping 16 bits of weight
  assign mulh_sum         = $signed(int_result) + $signed({mulh_acc[mdu_op_pkg::XLEN], mulh_acc});
  assign mulh_sum_shifted = $signed(mulh_sum) >>> 16;
  assign mulh_result      = mulh_shift ? mulh_sum_shifted : mulh_sum;

  ////////////////////////////////////////////////////////////////////////////
  // High-half sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mulh_shift      = 1'b0;
    mulh_busy       = 1'b0;
    mulh_a          = mulh_al;
    mulh_b          = mulh_bl;
    mulh_state_next = mulh_state;

    case (mulh_state)
      mdu_state_pkg::ALBL: begin
        // Idle, the issue cycle already forms AL*BL
        mulh_shift = 1'b1;
        if (mulh_active) begin
          mulh_busy       = 1'b1;
          mulh_state_next = mdu_state_pkg::ALBH;
        end
      end
      mdu_state_pkg::ALBH: begin
        mulh_busy       = 1'b1;
        mulh_b          = mulh_bh;
        mulh_state_next = mdu_state_pkg::AHBL;
      end
      mdu_state_pkg::AHBL: begin
        mulh_busy       = 1'b1;
        mulh_shift      = 1'b1;
        mulh_a          = mulh_ah;
        mulh_state_next = mdu_state_pkg::AHBH;
      end
      mdu_state_pkg::AHBH: begin
        // Final sum is the result, held until the stage accepts it
        mulh_a = mulh_ah;
        mulh_b = mulh_bh;
        if (req.ex_ready) begin
          mulh_state_next = mdu_state_pkg::ALBL;
        end
      end
      default: mulh_state_next = mdu_state_pkg::ALBL;
    endcase
  end

  // Ready stays high unless a MULH is actually in flight
  assign ready_o = ~(mulh_busy & mulh_active);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_acc   <= '0;
      mulh_state <= mdu_state_pkg::ALBL;
    end else if (mulh_active) begin
      if (mulh_busy) begin
        mulh_acc <= mulh_result[mdu_op_pkg::XLEN:0];
      end else if (req.ex_ready) begin
        mulh_acc <= '0;  // Result taken, start clean
      end
      mulh_state <= mulh_state_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier and result select
  ////////////////////////////////////////////////////////////////////////////

  // Full operands for MUL, sign-extended halfwords otherwise
  assign op_a = (req.operator == mdu_op_pkg::MDU_MUL) ?
                {req.op_a[mdu_op_pkg::XLEN-1], req.op_a} : {{16{mulh_a[16]}}, mulh_a};
  assign op_b = (req.operator == mdu_op_pkg::MDU_MUL) ?
                {req.op_b[mdu_op_pkg::XLEN-1], req.op_b} : {{16{mulh_b[16]}}, mulh_b};

  assign int_prod   = $signed(op_a) * $signed(op_b);
  assign int_result = int_prod[mdu_op_pkg::XLEN+1:0];

  assign result_o = (req.operator == mdu_op_pkg::MDU_MUL) ?
                    int_result[mdu_op_pkg::XLEN-1:0] : mulh_result[mdu_op_pkg::XLEN-1:0];

endmodule

// File: logic/mdu_div.sv
/* Radix-2 restoring divider on operand magnitudes, one bit per cycle
   Signs and divide-by-zero are resolved by the result merge block */

`timescale 1ns/1ps

module mdu_div (
  input  logic                         clk,
  input  logic                         rst_n,
  mdu_req_if.unit                      req,
  output logic [mdu_op_pkg::XLEN-1:0]  quot_mag_o,
  output logic [mdu_op_pkg::XLEN-1:0]  rem_mag_o,
  output logic                         ready_o
);

  logic                               div_active;
  logic                               signed_op;
  mdu_state_pkg::div_state_e          state;
  logic [mdu_op_pkg::DIV_CNT_W-1:0]   step_cnt;

  // Operand magnitudes taken at issue
  logic [mdu_op_pkg::XLEN-1:0]        abs_a;
  logic [mdu_op_pkg::XLEN-1:0]        abs_b;

  // Working registers
  logic [mdu_op_pkg::XLEN-1:0]        rem_q;
  logic [mdu_op_pkg::XLEN-1:0]        quo_q;      // Dividend bits out, quotient bits in
  logic [mdu_op_pkg::XLEN-1:0]        divisor_q;

  // One restoring step
  logic [mdu_op_pkg::XLEN:0]          partial;
  logic [mdu_op_pkg::XLEN+1:0]        diff;
  logic                               fits;

  assign div_active = req.enable && ((req.operator == mdu_op_pkg::MDU_DIV) ||
                                     (req.operator == mdu_op_pkg::MDU_REM));

  assign signed_op = (req.short_signed == mdu_op_pkg::SIGNED_SIGNED);

  // Negate only signed negatives; the most negative value maps onto itself
  assign abs_a = (signed_op && req.op_a[mdu_op_pkg::XLEN-1]) ? -req.op_a : req.op_a;
  assign abs_b = (signed_op && req.op_b[mdu_op_pkg::XLEN-1]) ? -req.op_b : req.op_b;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Bring down the next dividend bit and try the subtraction
  assign partial = {rem_q, quo_q[mdu_op_pkg::XLEN-1]};
  assign diff    = {1'b0, partial} - {2'b00, divisor_q};
  assign fits    = ~diff[mdu_op_pkg::XLEN+1];

  always_ff @(posedge clk) begin
    if (div_active && (state == mdu_state_pkg::DIV_IDLE)) begin
      rem_q     <= '0;
      quo_q     <= abs_a;
      divisor_q <= abs_b;
    end else if (div_active && (state == mdu_state_pkg::DIV_RUN)) begin
      // Keep the difference only when the divisor fit
      rem_q <= fits ? diff[mdu_op_pkg::XLEN-1:0] : partial[mdu_op_pkg::XLEN-1:0];
      quo_q <= {quo_q[mdu_op_pkg::XLEN-2:0], fits};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mdu_state_pkg::DIV_IDLE;
      step_cnt <= '0;
    end else if (div_active) begin
      case (state)
        mdu_state_pkg::DIV_IDLE: begin
          state    <= mdu_state_pkg::DIV_RUN;
          step_cnt <= '0;
        end
        mdu_state_pkg::DIV_RUN: begin
          if (step_cnt == mdu_op_pkg::DIV_LAST) begin
            state <= mdu_state_pkg::DIV_DONE;
          end
          step_cnt <= step_cnt + 1'b1;
        end
        mdu_state_pkg::DIV_DONE: begin
          // Hold the result through a stall
          if (req.ex_ready) begin
            state <= mdu_state_pkg::DIV_IDLE;
          end
        end
        default: state <= mdu_state_pkg::DIV_IDLE;
      endcase
    end
  end

  // Low from issue through the last step when the operation is ours
  assign ready_o = ~div_active | (state == mdu_state_pkg::DIV_DONE);

  assign quot_mag_o = quo_q;
  assign rem_mag_o  = rem_q;

endmodule

// File: logic/mdu_result_merge.sv
/* Purely combinational; applies the RISC-V sign and divide-by-zero
   rules to the divider magnitudes and picks the final result */

`timescale 1ns/1ps

module mdu_result_merge (
  mdu_req_if.merge                     req,
  input  logic [mdu_op_pkg::XLEN-1:0]  mult_result_i,
  input  logic                         mult_ready_i,
  input  logic [mdu_op_pkg::XLEN-1:0]  quot_mag_i,
  input  logic [mdu_op_pkg::XLEN-1:0]  rem_mag_i,
  input  logic                         div_ready_i,
  output logic [mdu_op_pkg::XLEN-1:0]  result_o,
  output logic                         ready_o
);

  logic                         signed_op;
  logic                         a_neg;
  logic                         b_neg;
  logic                         div_by_zero;
  logic [mdu_op_pkg::XLEN-1:0]  quot;
  logic [mdu_op_pkg::XLEN-1:0]  rem;

  assign signed_op   = (req.short_signed == mdu_op_pkg::SIGNED_SIGNED);
  assign a_neg       = signed_op & req.op_a[mdu_op_pkg::XLEN-1];
  assign b_neg       = signed_op & req.op_b[mdu_op_pkg::XLEN-1];
  assign div_by_zero = (req.op_b == '0);

  // Quotient is negative when the operand signs differ
  // Divide by zero returns all ones without sign correction
  assign quot = div_by_zero    ? '1 :
                (a_neg ^ b_neg) ? -quot_mag_i : quot_mag_i;

  // Remainder follows the dividend sign, or is the dividend itself on zero
  assign rem = div_by_zero ? req.op_a :
               a_neg       ? -rem_mag_i : rem_mag_i;

  always_comb begin
    case (req.operator)
      mdu_op_pkg::MDU_DIV: result_o = quot;
      mdu_op_pkg::MDU_REM: result_o = rem;
      default:             result_o = mult_result_i;
    endcase
  end

  // An idle unit holds its ready high
  assign ready_o = mult_ready_i & div_ready_i;

endmodule

// File: logic/mdu_top.sv
/* Multiply/divide unit with plain ports; latency is that of the selected
   unit, and inputs must be held until ready_o is seen with ex_ready_i */

`timescale 1ns/1ps

module mdu_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         enable_i,
  input  mdu_op_pkg::mdu_op_e          operator_i,
  input  logic [1:0]                   short_signed_i,
  input  logic [mdu_op_pkg::XLEN-1:0]  op_a_i,
  input  logic [mdu_op_pkg::XLEN-1:0]  op_b_i,
  input  logic                         ex_ready_i,
  output logic [mdu_op_pkg::XLEN-1:0]  result_o,
  output logic                         ready_o
);

  logic [mdu_op_pkg::XLEN-1:0]  mult_result;
  logic                         mult_ready;
  logic [mdu_op_pkg::XLEN-1:0]  quot_mag;
  logic [mdu_op_pkg::XLEN-1:0]  rem_mag;
  logic                         div_ready;

  // Request bundle shared by all three blocks
  mdu_req_if req_if ();

  assign req_if.enable       = enable_i;
  assign req_if.operator     = operator_i;
  assign req_if.short_signed = short_signed_i;
  assign req_if.op_a         = op_a_i;
  assign req_if.op_b         = op_b_i;
  assign req_if.ex_ready     = ex_ready_i;

  mdu_mult u_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req_if),
    .result_o (mult_result),
    .ready_o  (mult_ready)
  );

  mdu_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req_if),
    .quot_mag_o (quot_mag),
    .rem_mag_o  (rem_mag),
    .ready_o    (div_ready)
  );

  mdu_result_merge u_merge (
    .req           (req_if),
    .mult_result_i (mult_result),
    .mult_ready_i  (mult_ready),
    .quot_mag_i    (quot_mag),
    .rem_mag_i     (rem_mag),
    .div_ready_i   (div_ready),
    .result_o      (result_o),
    .ready_o       (ready_o)
  );

endmodule

// File: tb/mdu_tb.sv
/* Self-checking testbench for mdu_top with vectors read from tb/mdu_testdata.txt
   Must run from the project root; every wait for ready_o gives up after 64 cycles */

`timescale 1ns/1ps

module mdu_tb;

  // Longest legal wait is the 33-cycle divide
  localparam int WAIT_LIMIT = 64;

  logic                         clk;
  logic                         rst_n;
  logic                         enable_i;
  mdu_op_pkg::mdu_op_e          operator_i;
  logic [1:0]                   short_signed_i;
  logic [mdu_op_pkg::XLEN-1:0]  op_a_i;
  logic [mdu_op_pkg::XLEN-1:0]  op_b_i;
  logic                         ex_ready_i;
  logic [mdu_op_pkg::XLEN-1:0]  result_o;
  logic                         ready_o;

  integer seed;
  int     test_count;
  int     fail_count;
  bit     timed_out;

  mdu_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (enable_i),
    .operator_i     (operator_i),
    .short_signed_i (short_signed_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .ex_ready_i     (ex_ready_i),
    .result_o       (result_o),
    .ready_o        (ready_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Mnemonic from the vector file to operation code
  function automatic mdu_op_pkg::mdu_op_e decode_op(input string word);
    case (word)
      "MULH":  return mdu_op_pkg::MDU_MULH;
      "DIV":   return mdu_op_pkg::MDU_DIV;
      "REM":   return mdu_op_pkg::MDU_REM;
      default: return mdu_op_pkg::MDU_MUL;
    endcase
  endfunction

  // Cycles with ready_o low, issue cycle included
  function automatic int expected_low_cycles(input mdu_op_pkg::mdu_op_e op);
    case (op)
      mdu_op_pkg::MDU_MUL:  return 0;
      mdu_op_pkg::MDU_MULH: return 3;
      default:              return 33;
    endcase
  endfunction

  // Issue one operation, check result and latency, then stall and release
  task automatic run_vector(input string name, input mdu_op_pkg::mdu_op_e op,
                            input logic [1:0] sgn, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] exp_result, input int stall);
    int          low_cycles;
    int          waited;
    int          errors;
    low_cycles = 0;
    waited     = 0;
    errors     = 0;
    // Drive on the falling edge with the result not yet taken
    enable_i       = 1'b1;
    operator_i     = op;
    short_signed_i = sgn;
    op_a_i         = a;
    op_b_i         = b;
    ex_ready_i     = 1'b0;
    // Sample the issue-cycle ready in the middle of the low phase
    #1;
    if (!ready_o) low_cycles++;
    @(negedge clk);
    while (!ready_o && waited < WAIT_LIMIT) begin
      low_cycles++;
      waited++;
      @(negedge clk);
    end
    if (!ready_o) begin
      $display("Timeout: ready_o stayed low for %0d cycles in test %s", WAIT_LIMIT, name);
      timed_out = 1'b1;
      errors++;
    end else begin
      if (result_o !== exp_result) begin
        $display("Error: %s result expected %h actual %h", name, exp_result, result_o);
        errors++;
      end
      if (low_cycles != expected_low_cycles(op)) begin
        $display("Error: %s ready_o low cycles expected %0d actual %0d",
                 name, expected_low_cycles(op), low_cycles);
        errors++;
      end
      // Result and ready must not move under back-pressure
      repeat (stall) begin
        @(negedge clk);
        if (ready_o !== 1'b1) begin
          $display("Error: %s stall ready_o expected 1 actual %b", name, ready_o);
          errors++;
        end
        if (result_o !== exp_result) begin
          $display("Error: %s stall result expected %h actual %h", name, exp_result, result_o);
          errors++;
        end
      end
      // Release the result so the next issue goes out on the following falling edge
      ex_ready_i = 1'b1;
      @(negedge clk);
    end
    test_count++;
    if (errors == 0) begin
      $display("PASS %s (stall %0d)", name, stall);
    end else begin
      $display("FAIL %s", name);
      fail_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    string       line;
    string       name;
    string       op_word;
    logic [1:0]  sgn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_result;
    int          stall;
    int          fd;
    int          vectors;
    seed           = 32'h6e32_0ba0;
    test_count     = 0;
    fail_count     = 0;
    vectors        = 0;
    timed_out      = 1'b0;
    rst_n          = 1'b0;
    enable_i       = 1'b0;
    operator_i     = mdu_op_pkg::MDU_MUL;
    short_signed_i = 2'b00;
    op_a_i         = '0;
    op_b_i         = '0;
    ex_ready_i     = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle unit reports ready
    test_count++;
    if (ready_o !== 1'b1) begin
      $display("Error: after_reset ready_o expected 1 actual %b", ready_o);
      $display("FAIL after_reset");
      fail_count++;
    end else begin
      $display("PASS after_reset");
    end
    fd = $fopen("tb/mdu_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/mdu_testdata.txt");
      fail_count++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        // Skip comments and blank lines
        if (line.len() < 2 || line[0] == "#") continue;
        if ($sscanf(line, "%s %s %b %h %h %h %d", name, op_word, sgn, a, b, exp_result,
                    stall) != 7) begin
          $display("Malformed vector line: %s", line);
          fail_count++;
          continue;
        end
        vectors++;
        run_vector(name, decode_op(op_word), sgn, a, b, exp_result,
                   stall + int'($unsigned($random(seed)) % 4));
      end
      $fclose(fd);
    end
    if (vectors == 0) begin
      $display("No test vectors were read");
      fail_count++;
    end
    enable_i = 1'b0;
    $display("Tests run: %0d, failed: %0d", test_count, fail_count);
    if (fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tb/mdu_testdata.txt
# name  op  sign(b,a)  op_a  op_b  expected  stall
# sign is binary with bit 1 for op_b and bit 0 for op_a, operands and result hex, stall decimal
mul_neg        MUL  11 ffffffff 00000007 fffffff9 0
mul_max        MUL  11 7fffffff 7fffffff 00000001 2
mulh_min_min   MULH 11 80000000 80000000 40000000 0
mulh_neg_pos   MULH 11 fffffffe 00000003 ffffffff 4
mulhsu_neg_max MULH 01 ffffffff ffffffff ffffffff 0
mulhu_max      MULH 00 ffffffff ffffffff fffffffe 1
mulh_max       MULH 11 7fffffff 7fffffff 3fffffff 0
div_neg_pos    DIV  11 fffffff9 00000002 fffffffd 0
rem_neg_pos    REM  11 fffffff9 00000002 ffffffff 5
rem_pos_neg    REM  11 00000007 fffffffe 00000001 0
divu_max       DIV  00 ffffffff 00000010 0fffffff 0
div_overflow   DIV  11 80000000 ffffffff 80000000 3
rem_overflow   REM  11 80000000 ffffffff 00000000 0
div_zero       DIV  11 fffffff9 00000000 ffffffff 2
rem_zero       REM  11 fffffff9 00000000 fffffff9 0
remu_zero      REM  00 12345678 00000000 12345678 0

// File: mdu_top.f
logic/mdu_op_pkg.sv
logic/mdu_state_pkg.sv
logic/mdu_req_if.sv
logic/mdu_mult.sv
logic/mdu_div.sv
logic/mdu_result_merge.sv
logic/mdu_top.sv
tb/mdu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MDU testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f mdu_top.f --top-module mdu_tb \
  --Mdir obj_dir -o mdu_sim

./obj_dir/mdu_sim > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
